// ==== Bender.yml ====
package:
  name: rename_core

sources:
  - src/rename_pkg.sv
  - src/free_list.sv
  - src/map_table.sv
  - src/rename_stage.sv
  - src/reorder_buffer.sv
  - src/rename_top.sv
  - target: simulation
    files:
      - test/tb_clock_gen.sv
      - test/tb_rename_top.sv

// ==== compile.f ====
src/rename_pkg.sv
src/free_list.sv
src/map_table.sv
src/rename_stage.sv
src/reorder_buffer.sv
src/rename_top.sv
test/tb_clock_gen.sv
test/tb_rename_top.sv

// ==== src/free_list.sv ====
// Physical register free list
// One free bit per physical tag, lowest free tag offered first.
// Retired tags come back through the free port.

`timescale 1ns/1ns
`default_nettype none

module free_list (
    input  logic                clock,
    input  logic                arst_n,
    // Allocation from rename
    input  logic                alloc_req,
    output rename_pkg::phys_tag_t alloc_tag,
    // Return from retirement
    input  logic                free_valid,
    input  rename_pkg::phys_tag_t free_tag,
    // Status
    output logic                has_free
);

    import rename_pkg::*;

    // Set bit means tag is free
    logic [PHYS_REGS-1:0] free_bits;

    ////////////////////////////////////////////////////////////
    // Priority search, lowest index wins
    ////////////////////////////////////////////////////////////

    always_comb begin
        alloc_tag = '0;
        // Scan downward so the last hit is the lowest tag
        for (int i = PHYS_REGS - 1; i >= 0; i--) begin
            if (free_bits[i]) begin
                alloc_tag = phys_tag_t'(i);
            end
        end
    end

    assign has_free = |free_bits;

    ////////////////////////////////////////////////////////////
    // Free bit update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            // Tags above the architectural range start free
            for (int i = 0; i < PHYS_REGS; i++) begin
                free_bits[i] <= (i >= ARCH_REGS);
            end
        end else begin
            if (alloc_req) begin
                free_bits[alloc_tag] <= 1'b0;
            end
            // A returned tag is never the one on offer
            if (free_valid) begin
                free_bits[free_tag] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/map_table.sv ====
// Speculative rename map
// Architectural register to physical tag, three read ports and one
// write port. Comes out of reset as the identity mapping.

`timescale 1ns/1ns
`default_nettype none

module map_table (
    input  logic                  clock,
    input  logic                  arst_n,
    // Read ports, combinational
    input  rename_pkg::arch_idx_t rs1_idx,
    input  rename_pkg::arch_idx_t rs2_idx,
    input  rename_pkg::arch_idx_t rd_idx,
    output rename_pkg::phys_tag_t rs1_tag,
    output rename_pkg::phys_tag_t rs2_tag,
    output rename_pkg::phys_tag_t rd_old_tag,
    // Write port, takes effect at the edge
    input  logic                  write_en,
    input  rename_pkg::arch_idx_t write_idx,
    input  rename_pkg::phys_tag_t write_tag
);

    import rename_pkg::*;

    phys_tag_t map_q [ARCH_REGS];

    // Reads show the mapping before this cycle's write
    assign rs1_tag    = map_q[rs1_idx];
    assign rs2_tag    = map_q[rs2_idx];
    assign rd_old_tag = map_q[rd_idx];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            // Identity, register i lives in tag i
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
        end else if (write_en) begin
            map_q[write_idx] <= write_tag;
        end
    end

endmodule

`default_nettype wire

// ==== src/rename_pkg.sv ====
// Register renaming package
// Architectural and physical register counts, plus the index and tag
// types shared by the rename, free list and reorder buffer blocks

`default_nettype none

package rename_pkg;

    ////////////////////////////////////////////////////////////
    // Register file sizes
    ////////////////////////////////////////////////////////////

    // Architectural registers visible to software
    localparam int ARCH_REGS = 32;
    // Physical registers behind the rename map
    localparam int PHYS_REGS = 64;

    // Hardwired zero, never renamed
    localparam int ZERO_REG = 0;

    ////////////////////////////////////////////////////////////
    // Index and tag types
    ////////////////////////////////////////////////////////////

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_idx_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_tag_t;

endpackage

`default_nettype wire

// ==== src/rename_stage.sv ====
// Rename stage
// Reads the map for both sources and the destination, takes a new tag
// for a real destination and updates the map, then holds the renamed
// instruction in its output register for one cycle.

`timescale 1ns/1ns
`default_nettype none

module rename_stage (
    input  logic                  clock,
    input  logic                  arst_n,
    // Decoded instruction in
    input  logic                  dispatch_valid,
    input  rename_pkg::arch_idx_t dispatch_rd,
    input  rename_pkg::arch_idx_t dispatch_rs1,
    input  rename_pkg::arch_idx_t dispatch_rs2,
    // Map reads
    output rename_pkg::arch_idx_t rs1_idx,
    output rename_pkg::arch_idx_t rs2_idx,
    output rename_pkg::arch_idx_t rd_idx,
    input  rename_pkg::phys_tag_t rs1_tag,
    input  rename_pkg::phys_tag_t rs2_tag,
    input  rename_pkg::phys_tag_t rd_old_tag,
    // Map write
    output logic                  write_en,
    output rename_pkg::arch_idx_t write_idx,
    output rename_pkg::phys_tag_t write_tag,
    // Free list
    output logic                  alloc_req,
    input  rename_pkg::phys_tag_t alloc_tag,
    // Renamed instruction out
    output logic                  renamed_valid,
    output rename_pkg::arch_idx_t renamed_rd,
    output rename_pkg::phys_tag_t renamed_rs1_tag,
    output rename_pkg::phys_tag_t renamed_rs2_tag,
    output rename_pkg::phys_tag_t renamed_rd_tag,
    output rename_pkg::phys_tag_t renamed_old_tag,
    output logic                  renamed_uses_rd
);

    import rename_pkg::*;

    logic uses_rd;

    ////////////////////////////////////////////////////////////
    // Dispatch cycle, combinational
    ////////////////////////////////////////////////////////////

    // Writes to the zero register need no tag
    assign uses_rd = dispatch_valid && (dispatch_rd != arch_idx_t'(ZERO_REG));

    assign rs1_idx = dispatch_rs1;
    assign rs2_idx = dispatch_rs2;
    assign rd_idx  = dispatch_rd;

    // Allocation and map update land on the same edge
    assign alloc_req = uses_rd;
    assign write_en  = uses_rd;
    assign write_idx = dispatch_rd;
    assign write_tag = alloc_tag;

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            renamed_valid <= 1'b0;
        end else begin
            renamed_valid <= dispatch_valid;
        end
    end

    // Payload, only loaded with a live instruction
    always_ff @(posedge clock) begin
        if (dispatch_valid) begin
            renamed_rd      <= dispatch_rd;
            renamed_rs1_tag <= rs1_tag;
            renamed_rs2_tag <= rs2_tag;
            renamed_uses_rd <= uses_rd;
            // Zero tags when there is no destination
            renamed_rd_tag  <= uses_rd ? alloc_tag : '0;
            renamed_old_tag <= uses_rd ? rd_old_tag : '0;
        end
    end

endmodule

`default_nettype wire

// ==== src/rename_top.sv ====
// Rename and retire core
// Map table, free list, rename stage and reorder buffer, with the
// dispatch ready status formed from free tags and ROB room.

`timescale 1ns/1ns
`default_nettype none

module rename_top #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clock,
    input  logic                         arst_n,
    // Dispatch
    input  logic                         dispatch_valid,
    input  rename_pkg::arch_idx_t        dispatch_rd,
    input  rename_pkg::arch_idx_t        dispatch_rs1,
    input  rename_pkg::arch_idx_t        dispatch_rs2,
    output logic                         dispatch_ready,
    // Completion
    input  logic                         complete_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] complete_rob_idx,
    // Rename result
    output logic                         renamed_valid,
    output rename_pkg::phys_tag_t        renamed_rs1_tag,
    output rename_pkg::phys_tag_t        renamed_rs2_tag,
    output rename_pkg::phys_tag_t        renamed_rd_tag,
    output rename_pkg::phys_tag_t        renamed_old_tag,
    output logic                         renamed_uses_rd,
    output logic [$clog2(ROB_DEPTH)-1:0] renamed_rob_idx,
    // Retirement
    output logic                         retire_valid,
    output rename_pkg::arch_idx_t        retire_rd,
    output rename_pkg::phys_tag_t        retire_tag
);

    import rename_pkg::*;

    ////////////////////////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////////////////////////

    // Map table ports
    arch_idx_t rs1_idx, rs2_idx, rd_idx, write_idx;
    phys_tag_t rs1_tag, rs2_tag, rd_old_tag, write_tag;
    logic      write_en;

    // Free list traffic
    logic      alloc_req, free_valid, has_free;
    phys_tag_t alloc_tag, free_tag;

    // Rename to ROB
    arch_idx_t renamed_rd;
    logic      has_room;

    // Both resources needed before the source may strobe
    assign dispatch_ready = has_free && has_room;

    ////////////////////////////////////////////////////////////
    // Instances
    ////////////////////////////////////////////////////////////

    free_list u_free_list (
        .clock      (clock),
        .arst_n     (arst_n),
        .alloc_req  (alloc_req),
        .alloc_tag  (alloc_tag),
        .free_valid (free_valid),
        .free_tag   (free_tag),
        .has_free   (has_free)
    );

    map_table u_map_table (
        .clock      (clock),
        .arst_n     (arst_n),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rd_idx     (rd_idx),
        .rs1_tag    (rs1_tag),
        .rs2_tag    (rs2_tag),
        .rd_old_tag (rd_old_tag),
        .write_en   (write_en),
        .write_idx  (write_idx),
        .write_tag  (write_tag)
    );

    rename_stage u_rename_stage (
        .clock           (clock),
        .arst_n          (arst_n),
        .dispatch_valid  (dispatch_valid),
        .dispatch_rd     (dispatch_rd),
        .dispatch_rs1    (dispatch_rs1),
        .dispatch_rs2    (dispatch_rs2),
        .rs1_idx         (rs1_idx),
        .rs2_idx         (rs2_idx),
        .rd_idx          (rd_idx),
        .rs1_tag         (rs1_tag),
        .rs2_tag         (rs2_tag),
        .rd_old_tag      (rd_old_tag),
        .write_en        (write_en),
        .write_idx       (write_idx),
        .write_tag       (write_tag),
        .alloc_req       (alloc_req),
        .alloc_tag       (alloc_tag),
        .renamed_valid   (renamed_valid),
        .renamed_rd      (renamed_rd),
        .renamed_rs1_tag (renamed_rs1_tag),
        .renamed_rs2_tag (renamed_rs2_tag),
        .renamed_rd_tag  (renamed_rd_tag),
        .renamed_old_tag (renamed_old_tag),
        .renamed_uses_rd (renamed_uses_rd)
    );

    // ROB entry allocated in the cycle the rename register is valid
    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_reorder_buffer (
        .clock          (clock),
        .arst_n         (arst_n),
        .alloc_valid    (renamed_valid),
        .alloc_rd       (renamed_rd),
        .alloc_old_tag  (renamed_old_tag),
        .alloc_uses_rd  (renamed_uses_rd),
        .alloc_idx      (renamed_rob_idx),
        .has_room       (has_room),
        .complete_valid (complete_valid),
        .complete_idx   (complete_rob_idx),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_tag     (retire_tag),
        .free_valid     (free_valid),
        .free_tag       (free_tag)
    );

endmodule

`default_nettype wire

// ==== src/reorder_buffer.sv ====
// Reorder buffer
// Circular buffer of renamed instructions. Marks completions by index
// and retires the head in order, returning its old tag to the free list.

`timescale 1ns/1ns
`default_nettype none

module reorder_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clock,
    input  logic                         arst_n,
    // Allocation from rename
    input  logic                         alloc_valid,
    input  rename_pkg::arch_idx_t        alloc_rd,
    input  rename_pkg::phys_tag_t        alloc_old_tag,
    input  logic                         alloc_uses_rd,
    output logic [$clog2(ROB_DEPTH)-1:0] alloc_idx,
    output logic                         has_room,
    // Completion from execution
    input  logic                         complete_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] complete_idx,
    // Retirement report
    output logic                         retire_valid,
    output rename_pkg::arch_idx_t        retire_rd,
    output rename_pkg::phys_tag_t        retire_tag,
    // Tag return to free list
    output logic                         free_valid,
    output rename_pkg::phys_tag_t        free_tag
);

    import rename_pkg::*;

    localparam int IDX_W = $clog2(ROB_DEPTH);

    // Keeps a slot for the instruction still in rename
    localparam logic [IDX_W:0] ROOM_MAX = (IDX_W + 1)'(ROB_DEPTH - 2);

    // Entry payload
    arch_idx_t rd_q      [ROB_DEPTH];
    phys_tag_t old_tag_q [ROB_DEPTH];
    logic      uses_rd_q [ROB_DEPTH];

    // Entry and pointer state
    logic [ROB_DEPTH-1:0] complete_q;
    logic [IDX_W-1:0]     head_q;
    logic [IDX_W-1:0]     tail_q;
    logic [IDX_W:0]       count_q;

    logic do_retire;

    ////////////////////////////////////////////////////////////
    // Status and retire decision
    ////////////////////////////////////////////////////////////

    assign alloc_idx = tail_q;
    assign has_room  = (count_q <= ROOM_MAX);

    // Head must exist and be done
    assign do_retire = (count_q != '0) && complete_q[head_q];

    // Tag goes back at the retire edge, usable the cycle after
    assign free_valid = do_retire && uses_rd_q[head_q];
    assign free_tag   = old_tag_q[head_q];

    ////////////////////////////////////////////////////////////
    // Pointers, count and completion bits
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            complete_q   <= '0;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= do_retire;
            if (alloc_valid) begin
                complete_q[tail_q] <= 1'b0;
                // Power-of-two depth, pointer wraps by itself
                tail_q <= tail_q + 1'b1;
            end
            if (complete_valid) begin
                complete_q[complete_idx] <= 1'b1;
            end
            if (do_retire) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc_valid, do_retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Entry payload and retire report
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (alloc_valid) begin
            rd_q[tail_q]      <= alloc_rd;
            old_tag_q[tail_q] <= alloc_old_tag;
            uses_rd_q[tail_q] <= alloc_uses_rd;
        end
        if (do_retire) begin
            retire_rd  <= rd_q[head_q];
            retire_tag <= old_tag_q[head_q];
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
// Testbench clock and reset
// Free-running clock, reset held low for the first few cycles

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Release away from the edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #(PERIOD / 4) arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/tb_rename_top.sv ====
// Testbench for the rename and retire core
// Random dispatch and completion from a fixed seed, checked each cycle
// against a reference map, free list and ROB model

`timescale 1ns/1ns
`default_nettype none

module tb_rename_top;

    import rename_pkg::*;

    localparam int ROB_DEPTH     = 8;
    localparam int IDX_W         = $clog2(ROB_DEPTH);
    localparam int NUM_DISPATCH  = 2000;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_TIMEOUT = 50;
    localparam int RUN_TIMEOUT   = 20000;
    localparam int DRAIN_TIMEOUT = 500;

    logic             clock;
    logic             arst_n;
    logic             dispatch_valid;
    arch_idx_t        dispatch_rd;
    arch_idx_t        dispatch_rs1;
    arch_idx_t        dispatch_rs2;
    logic             dispatch_ready;
    logic             complete_valid;
    logic [IDX_W-1:0] complete_rob_idx;
    logic             renamed_valid;
    phys_tag_t        renamed_rs1_tag;
    phys_tag_t        renamed_rs2_tag;
    phys_tag_t        renamed_rd_tag;
    phys_tag_t        renamed_old_tag;
    logic             renamed_uses_rd;
    logic [IDX_W-1:0] renamed_rob_idx;
    logic             retire_valid;
    arch_idx_t        retire_rd;
    phys_tag_t        retire_tag;

    ////////////////////////////////////////////////////////////
    // Reference model state during the current cycle
    ////////////////////////////////////////////////////////////

    int map_m [ARCH_REGS];
    bit free_m [PHYS_REGS];
    int head_m;
    int tail_m;
    // Rename register contents
    bit ren_v;
    bit ren_uses;
    int ren_rd;
    int ren_rs1_tag;
    int ren_rs2_tag;
    int ren_rd_tag;
    int ren_old_tag;
    // Retire register contents
    bit ret_v;
    int ret_rd;
    int ret_tag;
    // ROB entries, oldest first
    int rob_rd_q [$];
    int rob_old_q [$];
    bit rob_uses_q [$];
    bit rob_done_q [$];
    // Run statistics
    int n_dispatched;
    int n_renamed;
    int n_retired;
    int n_alloc;
    int ready_low;
    int ready_recover;
    bit ready_prev;
    int last_rd;

    tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(4)) u_clock_gen (
        .clock  (clock),
        .arst_n (arst_n)
    );

    rename_top #(.ROB_DEPTH(ROB_DEPTH)) dut (
        .clock            (clock),
        .arst_n           (arst_n),
        .dispatch_valid   (dispatch_valid),
        .dispatch_rd      (dispatch_rd),
        .dispatch_rs1     (dispatch_rs1),
        .dispatch_rs2     (dispatch_rs2),
        .dispatch_ready   (dispatch_ready),
        .complete_valid   (complete_valid),
        .complete_rob_idx (complete_rob_idx),
        .renamed_valid    (renamed_valid),
        .renamed_rs1_tag  (renamed_rs1_tag),
        .renamed_rs2_tag  (renamed_rs2_tag),
        .renamed_rd_tag   (renamed_rd_tag),
        .renamed_old_tag  (renamed_old_tag),
        .renamed_uses_rd  (renamed_uses_rd),
        .renamed_rob_idx  (renamed_rob_idx),
        .retire_valid     (retire_valid),
        .retire_rd        (retire_rd),
        .retire_tag       (retire_tag)
    );

    ////////////////////////////////////////////////////////////
    // Error reporting
    ////////////////////////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: expected 0x%h, got 0x%h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "run stopped at first error");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic int lowest_free();
        for (int i = 0; i < PHYS_REGS; i++) begin
            if (free_m[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < ARCH_REGS; i++) begin
            map_m[i] = i;
        end
        for (int i = 0; i < PHYS_REGS; i++) begin
            free_m[i] = (i >= ARCH_REGS);
        end
        head_m = 0;
        tail_m = 0;
        ren_v  = 1'b0;
        ret_v  = 1'b0;
    endtask

    // One clock edge with the inputs driven during the past cycle
    task automatic model_edge();
        bit do_retire;
        bit do_free;
        int freed;
        int pos;
        int new_tag;
        do_retire = (rob_rd_q.size() > 0) && rob_done_q[0];
        do_free   = do_retire && rob_uses_q[0];
        freed     = do_retire ? rob_old_q[0] : 0;
        ret_v     = do_retire;
        if (do_retire) begin
            ret_rd  = rob_rd_q[0];
            ret_tag = rob_old_q[0];
        end
        // Mark before popping so positions still line up
        if (complete_valid) begin
            pos = (int'(complete_rob_idx) - head_m + ROB_DEPTH) % ROB_DEPTH;
            rob_done_q[pos] = 1'b1;
        end
        if (do_retire) begin
            void'(rob_rd_q.pop_front());
            void'(rob_old_q.pop_front());
            void'(rob_uses_q.pop_front());
            void'(rob_done_q.pop_front());
            head_m = (head_m + 1) % ROB_DEPTH;
        end
        // Rename register occupant enters the ROB at the tail
        if (ren_v) begin
            rob_rd_q.push_back(ren_rd);
            rob_old_q.push_back(ren_old_tag);
            rob_uses_q.push_back(ren_uses);
            rob_done_q.push_back(1'b0);
            tail_m = (tail_m + 1) % ROB_DEPTH;
        end
        // New rename sees the free bits from before this edge
        ren_v = dispatch_valid;
        if (dispatch_valid) begin
            ren_rd      = dispatch_rd;
            ren_rs1_tag = map_m[dispatch_rs1];
            ren_rs2_tag = map_m[dispatch_rs2];
            ren_uses    = (dispatch_rd != ZERO_REG);
            ren_rd_tag  = 0;
            ren_old_tag = 0;
            if (ren_uses) begin
                new_tag = lowest_free();
                if (new_tag < 0) begin
                    fail_run("Reference free list ran empty on an allocation");
                end
                ren_rd_tag          = new_tag;
                ren_old_tag         = map_m[dispatch_rd];
                free_m[new_tag]     = 1'b0;
                map_m[dispatch_rd]  = new_tag;
                n_alloc++;
            end
        end
        if (do_free) begin
            free_m[freed] = 1'b1;
        end
    endtask

    function automatic bit model_ready();
        return (lowest_free() >= 0) && (rob_rd_q.size() <= ROB_DEPTH - 2);
    endfunction

    ////////////////////////////////////////////////////////////
    // Per-cycle check and drive
    ////////////////////////////////////////////////////////////

    task automatic check_outputs();
        check("renamed_valid", renamed_valid, ren_v);
        if (renamed_valid) begin
            n_renamed++;
        end
        if (ren_v) begin
            check("renamed_rs1_tag", renamed_rs1_tag, ren_rs1_tag);
            check("renamed_rs2_tag", renamed_rs2_tag, ren_rs2_tag);
            check("renamed_uses_rd", renamed_uses_rd, ren_uses);
            check("renamed_rd_tag", renamed_rd_tag, ren_rd_tag);
            check("renamed_old_tag", renamed_old_tag, ren_old_tag);
            check("renamed_rob_idx", renamed_rob_idx, tail_m);
        end
        check("retire_valid", retire_valid, ret_v);
        if (retire_valid) begin
            n_retired++;
        end
        if (ret_v) begin
            check("retire_rd", retire_rd, ret_rd);
            check("retire_tag", retire_tag, ret_tag);
        end
        check("dispatch_ready", dispatch_ready, model_ready());
        if (!dispatch_ready) begin
            ready_low++;
        end else if (!ready_prev) begin
            ready_recover++;
        end
        ready_prev = dispatch_ready;
    endtask

    task automatic drive_inputs(input bit may_dispatch, input bit may_complete);
        int open_pos [$];
        int pick;
        dispatch_valid = 1'b0;
        complete_valid = 1'b0;
        // Source only strobes while ready is high
        if (may_dispatch && dispatch_ready && ($urandom_range(3) != 0)) begin
            dispatch_valid = 1'b1;
            dispatch_rd    = ($urandom_range(7) == 0) ? '0 : arch_idx_t'($urandom);
            // Often read the previous destination right away
            dispatch_rs1   = ($urandom_range(3) == 0) ? arch_idx_t'(last_rd)
                                                      : arch_idx_t'($urandom);
            dispatch_rs2   = arch_idx_t'($urandom);
            last_rd        = dispatch_rd;
            n_dispatched++;
        end
        for (int p = 0; p < rob_done_q.size(); p++) begin
            if (!rob_done_q[p]) begin
                open_pos.push_back(p);
            end
        end
        if (may_complete && (open_pos.size() > 0) && ($urandom_range(3) != 0)) begin
            pick             = open_pos[$urandom_range(open_pos.size() - 1)];
            complete_valid   = 1'b1;
            complete_rob_idx = IDX_W'((head_m + pick) % ROB_DEPTH);
        end
    endtask

    task automatic step_cycle();
        @(posedge clock);
        #(DRIVE_DELAY);
        model_edge();
        check_outputs();
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin : main_flow
        int cycles;
        void'($urandom(53));
        dispatch_valid   = 1'b0;
        dispatch_rd      = '0;
        dispatch_rs1     = '0;
        dispatch_rs2     = '0;
        complete_valid   = 1'b0;
        complete_rob_idx = '0;
        ready_prev       = 1'b1;
        model_reset();

        cycles = 0;
        while (arst_n !== 1'b1) begin
            @(posedge clock);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                fail_run("Reset was never released");
            end
        end

        // Completions held back in bursts so the ROB fills up
        cycles = 0;
        while (n_dispatched < NUM_DISPATCH) begin
            step_cycle();
            drive_inputs(1'b1, (cycles % 128) < 100);
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                fail_run("Dispatch phase did not finish in time");
            end
        end

        // Drain until everything outstanding completes and retires
        cycles = 0;
        while (ren_v || ret_v || (rob_rd_q.size() > 0)) begin
            step_cycle();
            drive_inputs(1'b0, 1'b1);
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                fail_run("ROB did not drain in time");
            end
        end

        check("renamed count", n_renamed, n_dispatched);
        check("retired count", n_retired, n_dispatched);
        if (ready_low == 0 || ready_recover == 0) begin
            fail_run("dispatch_ready never dropped and recovered");
        end
        if (n_alloc < 10 * (PHYS_REGS - ARCH_REGS)) begin
            fail_run("Too few allocations to recycle the spare tags");
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
